//--- logic/numbat_pkg.sv
// --------------------------------------------------------------------------
// widths, register indices, entry field positions and vector types
// --------------------------------------------------------------------------
package numbat_pkg;

   // widths
   localparam int board_width = 256; // 64 squares of 4 bits
   localparam int eval_width = 24;
   localparam int move_idx_width = 8;
   localparam int half_move_width = 7;
   localparam int nodes_width = 28;
   localparam int word_width = 32; // width of the 32-bit registers

   typedef logic [board_width-1:0] board_t;
   typedef logic signed [eval_width-1:0] eval_t;
   typedef logic [move_idx_width-1:0] move_idx_t;
   typedef logic [half_move_width-1:0] half_move_t;
   typedef logic [nodes_width-1:0] nodes_t;
   typedef logic [7:0] depth_t;
   typedef logic [1:0] tt_flag_t;
   typedef logic [79:0] hash_t;
   typedef logic [3:0] castle_t;
   typedef logic [3:0] ep_col_t;
   typedef logic [13:0] reg_idx_t;
   typedef logic [127:0] bus_data_t;
   typedef logic [15:0] byte_en_t;

   // generator group
   localparam reg_idx_t reg_ctrl = 14'd0;
   localparam reg_idx_t reg_move_index = 14'd1;
   localparam reg_idx_t reg_position = 14'd2;
   localparam reg_idx_t reg_half_move = 14'd3;
   localparam reg_idx_t reg_quiescence = 14'd4;
   localparam reg_idx_t reg_castle_orig = 14'd5;
   localparam reg_idx_t reg_board_lo = 14'd8;
   localparam reg_idx_t reg_board_hi = 14'd9;
   localparam reg_idx_t reg_gen_flags = 14'd132;
   localparam reg_idx_t reg_gen_position = 14'd133;
   localparam reg_idx_t reg_gen_eval = 14'd134;
   localparam reg_idx_t reg_move_count = 14'd135;
   localparam reg_idx_t reg_root_eval = 14'd136;

   // table groups, base plus offset
   localparam reg_idx_t trans_base_main = 14'd512;
   localparam reg_idx_t trans_base_quiet = 14'd612;

   localparam reg_idx_t trans_off_result = 14'd0;
   localparam reg_idx_t trans_off_status = 14'd1;
   localparam reg_idx_t trans_off_entry = 14'd8;
   localparam reg_idx_t trans_off_cmd = 14'd9;
   localparam reg_idx_t trans_off_hash0 = 14'd10; // hash 31:0
   localparam reg_idx_t trans_off_hash1 = 14'd11; // hash 63:32
   localparam reg_idx_t trans_off_hash2 = 14'd12; // hash 79:64

   // entry word fields
   localparam int field_eval_lsb = 0;
   localparam int field_depth_lsb = 24;
   localparam int field_nodes_lsb = 32;
   localparam int field_flag_lsb = 61;
   localparam int field_capture_bit = 63;

   // lookup result word, other fields as in the entry
   localparam int result_valid_bit = 60;
   localparam int result_collision_bit = 63;

endpackage

//--- logic/move_gen_regs.sv
// --------------------------------------------------------------------------
// move generator position, index and control registers, status readback
// --------------------------------------------------------------------------
module move_gen_regs import numbat_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       wr_valid,
   input  reg_idx_t   idx,
   input  bus_data_t  din,
   input  byte_en_t   we,

   input  logic       gen_idle,
   input  logic       moves_ready,
   input  logic       move_ready,
   input  move_idx_t  move_count,
   input  logic       gen_board_white_to_move,
   input  castle_t    gen_castle,
   input  ep_col_t    gen_ep_col,
   input  eval_t      gen_eval,
   input  logic       gen_capture,
   input  logic       gen_white_in_check,
   input  logic       gen_black_in_check,
   input  logic       gen_fifty_move,
   input  logic       gen_insufficient,
   input  logic       root_mate,
   input  logic       root_stalemate,
   input  logic       root_fifty_move,
   input  logic       root_insufficient,
   input  logic       root_check,
   input  eval_t      root_eval,

   output logic       soft_reset,
   output logic       new_board_valid,
   output logic       clear_moves,
   output logic       quiescence_moves,
   output move_idx_t  move_index,
   output board_t     board,
   output logic       white_to_move,
   output castle_t    castle_mask,
   output castle_t    castle_mask_orig,
   output ep_col_t    ep_col,
   output half_move_t half_move,
   output bus_data_t  rd_data,
   output logic       rd_hit
);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         soft_reset <= 1'b0;
         new_board_valid <= 1'b0;
         clear_moves <= 1'b0;
         quiescence_moves <= 1'b0;
         move_index <= '0;
         board <= '0;
         white_to_move <= 1'b0;
         castle_mask <= '0;
         castle_mask_orig <= '0;
         ep_col <= '0;
         half_move <= '0;
      end
      else if (wr_valid)
      begin
         case (idx)
            reg_ctrl:
            begin
               new_board_valid <= din[0];
               clear_moves <= din[1];
               soft_reset <= din[31];
            end
            reg_move_index: move_index <= din[move_idx_width-1:0];
            reg_position: {white_to_move, castle_mask, ep_col} <= din[8:0];
            reg_half_move: half_move <= din[half_move_width-1:0];
            reg_quiescence: quiescence_moves <= din[0];
            reg_castle_orig: castle_mask_orig <= din[3:0];
            // board halves take each enabled byte on its own
            reg_board_lo:
               for (int i = 0; i < 16; i++)
                  if (we[i])
                     board[i*8 +: 8] <= din[i*8 +: 8];
            reg_board_hi:
               for (int i = 0; i < 16; i++)
                  if (we[i])
                     board[128 + i*8 +: 8] <= din[i*8 +: 8];
            default: ;
         endcase
      end
   end

   always_comb
   begin
      rd_data = '0;
      rd_hit = 1'b1;
      case (idx)
         reg_ctrl:
         begin
            rd_data[0] = new_board_valid;
            rd_data[1] = clear_moves;
            rd_data[2] = moves_ready;
            rd_data[3] = move_ready;
            rd_data[4] = root_stalemate;
            rd_data[5] = root_mate;
            rd_data[7] = gen_idle;
            rd_data[8] = root_fifty_move;
            rd_data[9] = root_insufficient;
            rd_data[10] = root_check;
            rd_data[31] = soft_reset;
         end
         reg_move_index: rd_data[move_idx_width-1:0] = move_index;
         reg_position: rd_data[8:0] = {white_to_move, castle_mask, ep_col};
         reg_half_move: rd_data[half_move_width-1:0] = half_move;
         reg_quiescence: rd_data[0] = quiescence_moves;
         reg_castle_orig: rd_data[3:0] = castle_mask_orig;
         reg_gen_flags: // bit 3 kept free
            rd_data[5:0] = {gen_insufficient, gen_fifty_move, 1'b0,
                            gen_black_in_check, gen_white_in_check, gen_capture};
         reg_gen_position: rd_data[8:0] = {gen_board_white_to_move, gen_castle, gen_ep_col};
         reg_gen_eval:
            rd_data[word_width-1:0] = {{(word_width-eval_width){gen_eval[eval_width-1]}},
                                       gen_eval};
         reg_move_count: rd_data[move_idx_width-1:0] = move_count;
         reg_root_eval:
            rd_data[word_width-1:0] = {{(word_width-eval_width){root_eval[eval_width-1]}},
                                       root_eval};
         default: rd_hit = 1'b0;
      endcase
   end

endmodule

//--- logic/trans_regs.sv
// --------------------------------------------------------------------------
// one transposition table: entry and command registers, lookup readback
// --------------------------------------------------------------------------
module trans_regs import numbat_pkg::*;
#(
   parameter reg_idx_t base = trans_base_main
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      wr_valid,
   input  reg_idx_t  idx,
   input  bus_data_t din,

   input  logic      entry_valid,
   input  logic      collision,
   input  logic      capture_in,
   input  logic      idle,
   input  depth_t    depth_in,
   input  eval_t     eval_in,
   input  tt_flag_t  flag_in,
   input  nodes_t    nodes_in,
   input  hash_t     hash,

   output eval_t     eval_out,
   output depth_t    depth_out,
   output nodes_t    nodes_out,
   output tt_flag_t  flag_out,
   output logic      capture_out,
   output logic      lookup,
   output logic      store,
   output logic      hash_only,
   output logic      clear,
   output bus_data_t rd_data,
   output logic      rd_hit
);

   localparam reg_idx_t idx_result = reg_idx_t'(base + trans_off_result);
   localparam reg_idx_t idx_status = reg_idx_t'(base + trans_off_status);
   localparam reg_idx_t idx_entry = reg_idx_t'(base + trans_off_entry);
   localparam reg_idx_t idx_cmd = reg_idx_t'(base + trans_off_cmd);
   localparam reg_idx_t idx_hash0 = reg_idx_t'(base + trans_off_hash0);
   localparam reg_idx_t idx_hash1 = reg_idx_t'(base + trans_off_hash1);
   localparam reg_idx_t idx_hash2 = reg_idx_t'(base + trans_off_hash2);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         eval_out <= '0;
         depth_out <= '0;
         nodes_out <= '0;
         flag_out <= '0;
         capture_out <= 1'b0;
         {clear, hash_only, store, lookup} <= '0;
      end
      else
      begin
         {clear, hash_only, store, lookup} <= '0; // pulses last one cycle
         if (wr_valid && idx == idx_entry)
         begin
            eval_out <= din[field_eval_lsb +: eval_width];
            depth_out <= din[field_depth_lsb +: 8];
            nodes_out <= din[field_nodes_lsb +: nodes_width];
            flag_out <= din[field_flag_lsb +: 2];
            capture_out <= din[field_capture_bit];
         end
         if (wr_valid && idx == idx_cmd)
            {clear, hash_only, store, lookup} <= din[3:0];
      end
   end

   always_comb
   begin
      rd_data = '0;
      rd_hit = 1'b1;
      case (idx)
         idx_result:
         begin
            rd_data[field_eval_lsb +: eval_width] = eval_in;
            rd_data[field_depth_lsb +: 8] = depth_in;
            rd_data[field_nodes_lsb +: nodes_width] = nodes_in;
            rd_data[result_valid_bit] = entry_valid;
            rd_data[field_flag_lsb +: 2] = flag_in;
            rd_data[result_collision_bit] = collision;
         end
         idx_status: rd_data[1:0] = {capture_in, idle};
         idx_hash0: rd_data[31:0] = hash[31:0];
         idx_hash1: rd_data[31:0] = hash[63:32];
         idx_hash2: rd_data[15:0] = hash[79:64];
         default: rd_hit = 1'b0; // entry and cmd are write only
      endcase
   end

endmodule

//--- logic/read_mux.sv
// --------------------------------------------------------------------------
// registered read data selection across the register groups
// --------------------------------------------------------------------------
module read_mux import numbat_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  bus_data_t gen_data,
   input  bus_data_t main_data,
   input  bus_data_t quiet_data,
   input  logic      gen_hit,
   input  logic      main_hit,
   input  logic      quiet_hit,
   output bus_data_t bus_dout
);

   // index ranges of the groups do not overlap, so at most one hit is high
   always_ff @(posedge clk)
   begin
      if (rst)
         bus_dout <= '0;
      else if (gen_hit)
         bus_dout <= gen_data;
      else if (main_hit)
         bus_dout <= main_data;
      else if (quiet_hit)
         bus_dout <= quiet_data;
      else
         bus_dout <= '0; // unmapped index
   end

endmodule

//--- logic/numbat_ctrl.sv
// --------------------------------------------------------------------------
// host register block: generator group, two table groups, read path
// --------------------------------------------------------------------------
module numbat_ctrl import numbat_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   input  logic [17:0] bus_addr,
   input  bus_data_t   bus_din,
   input  logic        bus_en,
   input  byte_en_t    bus_we,
   output bus_data_t   bus_dout,

   input  logic        gen_idle,
   input  logic        moves_ready,
   input  logic        move_ready,
   input  move_idx_t   move_count,
   input  logic        gen_board_white_to_move,
   input  castle_t     gen_castle,
   input  ep_col_t     gen_ep_col,
   input  eval_t       gen_eval,
   input  logic        gen_capture,
   input  logic        gen_white_in_check,
   input  logic        gen_black_in_check,
   input  logic        gen_fifty_move,
   input  logic        gen_insufficient,
   input  logic        root_mate,
   input  logic        root_stalemate,
   input  logic        root_fifty_move,
   input  logic        root_insufficient,
   input  logic        root_check,
   input  eval_t       root_eval,

   output logic        soft_reset,
   output logic        new_board_valid,
   output logic        clear_moves,
   output logic        quiescence_moves,
   output move_idx_t   move_index,
   output board_t      board,
   output logic        white_to_move,
   output castle_t     castle_mask,
   output castle_t     castle_mask_orig,
   output ep_col_t     ep_col,
   output half_move_t  half_move,

   input  logic        tt_entry_valid,
   input  logic        tt_collision,
   input  logic        tt_capture_in,
   input  logic        tt_idle,
   input  depth_t      tt_depth_in,
   input  eval_t       tt_eval_in,
   input  tt_flag_t    tt_flag_in,
   input  nodes_t      tt_nodes_in,
   input  hash_t       tt_hash,
   output eval_t       tt_eval_out,
   output depth_t      tt_depth_out,
   output nodes_t      tt_nodes_out,
   output tt_flag_t    tt_flag_out,
   output logic        tt_capture_out,
   output logic        tt_lookup,
   output logic        tt_store,
   output logic        tt_hash_only,
   output logic        tt_clear,

   input  logic        qt_entry_valid,
   input  logic        qt_collision,
   input  logic        qt_capture_in,
   input  logic        qt_idle,
   input  depth_t      qt_depth_in,
   input  eval_t       qt_eval_in,
   input  tt_flag_t    qt_flag_in,
   input  nodes_t      qt_nodes_in,
   input  hash_t       qt_hash,
   output eval_t       qt_eval_out,
   output depth_t      qt_depth_out,
   output nodes_t      qt_nodes_out,
   output tt_flag_t    qt_flag_out,
   output logic        qt_capture_out,
   output logic        qt_lookup,
   output logic        qt_store,
   output logic        qt_hash_only,
   output logic        qt_clear
);

   reg_idx_t  idx;
   logic      wr_valid;
   bus_data_t gen_data, main_data, quiet_data;
   logic      gen_hit, main_hit, quiet_hit;

   assign idx = bus_addr[17:4]; // 16-byte registers
   assign wr_valid = bus_en && (bus_we != '0);

   move_gen_regs move_gen_regs_inst (
      .clk, .rst, .wr_valid, .idx,
      .din (bus_din),
      .we (bus_we),
      .gen_idle, .moves_ready, .move_ready, .move_count,
      .gen_board_white_to_move, .gen_castle, .gen_ep_col, .gen_eval,
      .gen_capture, .gen_white_in_check, .gen_black_in_check,
      .gen_fifty_move, .gen_insufficient,
      .root_mate, .root_stalemate, .root_fifty_move, .root_insufficient,
      .root_check, .root_eval,
      .soft_reset, .new_board_valid, .clear_moves, .quiescence_moves,
      .move_index, .board, .white_to_move, .castle_mask, .castle_mask_orig,
      .ep_col, .half_move,
      .rd_data (gen_data),
      .rd_hit (gen_hit)
   );

   trans_regs #(.base(trans_base_main)) main_trans_inst (
      .clk, .rst, .wr_valid, .idx,
      .din (bus_din),
      .entry_valid (tt_entry_valid),
      .collision (tt_collision),
      .capture_in (tt_capture_in),
      .idle (tt_idle),
      .depth_in (tt_depth_in),
      .eval_in (tt_eval_in),
      .flag_in (tt_flag_in),
      .nodes_in (tt_nodes_in),
      .hash (tt_hash),
      .eval_out (tt_eval_out),
      .depth_out (tt_depth_out),
      .nodes_out (tt_nodes_out),
      .flag_out (tt_flag_out),
      .capture_out (tt_capture_out),
      .lookup (tt_lookup),
      .store (tt_store),
      .hash_only (tt_hash_only),
      .clear (tt_clear),
      .rd_data (main_data),
      .rd_hit (main_hit)
   );

   trans_regs #(.base(trans_base_quiet)) quiet_trans_inst (
      .clk, .rst, .wr_valid, .idx,
      .din (bus_din),
      .entry_valid (qt_entry_valid),
      .collision (qt_collision),
      .capture_in (qt_capture_in),
      .idle (qt_idle),
      .depth_in (qt_depth_in),
      .eval_in (qt_eval_in),
      .flag_in (qt_flag_in),
      .nodes_in (qt_nodes_in),
      .hash (qt_hash),
      .eval_out (qt_eval_out),
      .depth_out (qt_depth_out),
      .nodes_out (qt_nodes_out),
      .flag_out (qt_flag_out),
      .capture_out (qt_capture_out),
      .lookup (qt_lookup),
      .store (qt_store),
      .hash_only (qt_hash_only),
      .clear (qt_clear),
      .rd_data (quiet_data),
      .rd_hit (quiet_hit)
   );

   read_mux read_mux_inst (
      .clk, .rst,
      .gen_data, .main_data, .quiet_data,
      .gen_hit, .main_hit, .quiet_hit,
      .bus_dout
   );

endmodule

//--- bench/numbat_ctrl_tb.sv
// --------------------------------------------------------------------------
// clock, reset and random host bus traffic checked against a register model
// --------------------------------------------------------------------------
module numbat_ctrl_tb import numbat_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int p2_pairs = 300;    // write then read back
   localparam int p3_cycles = 500;   // board bytes
   localparam int p4_cycles = 600;   // table commands and entries
   localparam int p5_cycles = 700;   // status and result reads
   localparam int max_cycles = 3000; // test length is about 2400 cycles

   logic clk, rst;
   logic [17:0] bus_addr;
   bus_data_t bus_din, bus_dout;
   logic bus_en;
   byte_en_t bus_we;
   logic gen_idle, moves_ready, move_ready, gen_board_white_to_move;
   logic gen_capture, gen_white_in_check, gen_black_in_check, gen_fifty_move;
   logic gen_insufficient, root_mate, root_stalemate, root_fifty_move;
   logic root_insufficient, root_check;
   move_idx_t move_count;
   castle_t gen_castle;
   ep_col_t gen_ep_col;
   eval_t gen_eval, root_eval;
   logic soft_reset, new_board_valid, clear_moves, quiescence_moves, white_to_move;
   move_idx_t move_index;
   board_t board;
   castle_t castle_mask, castle_mask_orig;
   ep_col_t ep_col;
   half_move_t half_move;
   logic tt_entry_valid, tt_collision, tt_capture_in, tt_idle, tt_capture_out;
   logic qt_entry_valid, qt_collision, qt_capture_in, qt_idle, qt_capture_out;
   depth_t tt_depth_in, tt_depth_out, qt_depth_in, qt_depth_out;
   eval_t tt_eval_in, tt_eval_out, qt_eval_in, qt_eval_out;
   tt_flag_t tt_flag_in, tt_flag_out, qt_flag_in, qt_flag_out;
   nodes_t tt_nodes_in, tt_nodes_out, qt_nodes_in, qt_nodes_out;
   hash_t tt_hash, qt_hash;
   logic tt_lookup, tt_store, tt_hash_only, tt_clear;
   logic qt_lookup, qt_store, qt_hash_only, qt_clear;

   // register model with index 0 for the main table and 1 for the quiescence table
   logic exp_soft_reset, exp_new_board_valid, exp_clear_moves, exp_quiescence;
   logic exp_white_to_move;
   move_idx_t exp_move_index;
   board_t exp_board;
   castle_t exp_castle, exp_castle_orig;
   ep_col_t exp_ep_col;
   half_move_t exp_half_move;
   eval_t exp_eval [2];
   depth_t exp_depth [2];
   nodes_t exp_nodes [2];
   tt_flag_t exp_flag [2];
   logic exp_capture [2];
   logic [3:0] exp_pulses [2]; // {clear, hash_only, store, lookup}
   bus_data_t exp_dout;

   integer seed = 32'hed5c;
   integer errors = 0;
   integer checks = 0;
   integer cycles = 0;

   numbat_ctrl numbat_ctrl_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > max_cycles)
      begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("%0d checks, %0d errors", checks, errors);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
      checks = checks + 1;
      if (expected !== actual)
      begin
         errors = errors + 1;
         $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   function automatic bus_data_t random_word();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   // packed lookup result, status and hash words of one table
   function automatic bus_data_t table_read(reg_idx_t i, reg_idx_t base, logic valid,
                                            logic coll, logic cap, logic idl, depth_t d,
                                            eval_t e, tt_flag_t f, nodes_t n, hash_t h);
      bus_data_t w;
      w = '0;
      if (i == base + trans_off_result)
      begin
         w[23:0] = e;
         w[31:24] = d;
         w[59:32] = n;
         w[60] = valid;
         w[62:61] = f;
         w[63] = coll;
      end
      else if (i == base + trans_off_status)
         w[1:0] = {cap, idl};
      else if (i == base + trans_off_hash0)
         w[31:0] = h[31:0];
      else if (i == base + trans_off_hash1)
         w[31:0] = h[63:32];
      else if (i == base + trans_off_hash2)
         w[15:0] = h[79:64];
      return w;
   endfunction

   function automatic bus_data_t expected_read(reg_idx_t i);
      bus_data_t w;
      int v;
      w = '0;
      case (i)
         reg_ctrl:
            w[31:0] = {exp_soft_reset, 20'b0, root_check, root_insufficient,
                       root_fifty_move, gen_idle, 1'b0, root_mate, root_stalemate,
                       move_ready, moves_ready, exp_clear_moves, exp_new_board_valid};
         reg_move_index: w[7:0] = exp_move_index;
         reg_position: w[8:0] = {exp_white_to_move, exp_castle, exp_ep_col};
         reg_half_move: w[6:0] = exp_half_move;
         reg_quiescence: w[0] = exp_quiescence;
         reg_castle_orig: w[3:0] = exp_castle_orig;
         reg_gen_flags:
            w[5:0] = {gen_insufficient, gen_fifty_move, 1'b0, gen_black_in_check,
                      gen_white_in_check, gen_capture};
         reg_gen_position: w[8:0] = {gen_board_white_to_move, gen_castle, gen_ep_col};
         reg_gen_eval:
         begin
            v = gen_eval; // sign extends to 32 bits
            w[31:0] = v;
         end
         reg_move_count: w[7:0] = move_count;
         reg_root_eval:
         begin
            v = root_eval;
            w[31:0] = v;
         end
         default: ;
      endcase
      w = w | table_read(i, trans_base_main, tt_entry_valid, tt_collision, tt_capture_in,
                         tt_idle, tt_depth_in, tt_eval_in, tt_flag_in, tt_nodes_in, tt_hash);
      w = w | table_read(i, trans_base_quiet, qt_entry_valid, qt_collision, qt_capture_in,
                         qt_idle, qt_depth_in, qt_eval_in, qt_flag_in, qt_nodes_in, qt_hash);
      return w;
   endfunction

   task automatic reset_model();
      {exp_soft_reset, exp_new_board_valid, exp_clear_moves, exp_quiescence} = '0;
      {exp_white_to_move, exp_castle, exp_castle_orig, exp_ep_col} = '0;
      exp_move_index = '0;
      exp_board = '0;
      exp_half_move = '0;
      exp_dout = '0;
      for (int t = 0; t < 2; t++)
      begin
         {exp_eval[t], exp_depth[t], exp_nodes[t], exp_flag[t], exp_capture[t]} = '0;
         exp_pulses[t] = '0;
      end
   endtask

   // runs at the rising edge on the inputs that edge samples
   task automatic update_model();
      reg_idx_t i;
      reg_idx_t base;
      int half;
      i = bus_addr[17:4];
      if (rst)
      begin
         reset_model();
         return;
      end
      exp_dout = expected_read(i); // read sees the registers before this write
      exp_pulses[0] = '0;
      exp_pulses[1] = '0;
      if (!bus_en || bus_we == '0)
         return;
      case (i)
         reg_ctrl:
         begin
            exp_new_board_valid = bus_din[0];
            exp_clear_moves = bus_din[1];
            exp_soft_reset = bus_din[31];
         end
         reg_move_index: exp_move_index = bus_din[7:0];
         reg_position: {exp_white_to_move, exp_castle, exp_ep_col} = bus_din[8:0];
         reg_half_move: exp_half_move = bus_din[6:0];
         reg_quiescence: exp_quiescence = bus_din[0];
         reg_castle_orig: exp_castle_orig = bus_din[3:0];
         reg_board_lo, reg_board_hi:
         begin
            half = (i == reg_board_hi) ? 128 : 0;
            for (int b = 0; b < 16; b++)
               if (bus_we[b])
                  exp_board[half + 8*b +: 8] = bus_din[8*b +: 8];
         end
         default: ;
      endcase
      for (int t = 0; t < 2; t++)
      begin
         base = (t == 0) ? trans_base_main : trans_base_quiet;
         if (i == base + trans_off_entry)
         begin
            exp_eval[t] = bus_din[23:0];
            exp_depth[t] = bus_din[31:24];
            exp_nodes[t] = bus_din[59:32];
            exp_flag[t] = bus_din[62:61];
            exp_capture[t] = bus_din[63];
         end
         if (i == base + trans_off_cmd)
            exp_pulses[t] = bus_din[3:0];
      end
   endtask

   task automatic check_outputs();
      check_value("bus_dout", exp_dout, bus_dout);
      check_value("soft_reset", exp_soft_reset, soft_reset);
      check_value("new_board_valid", exp_new_board_valid, new_board_valid);
      check_value("clear_moves", exp_clear_moves, clear_moves);
      check_value("quiescence_moves", exp_quiescence, quiescence_moves);
      check_value("move_index", exp_move_index, move_index);
      check_value("board", exp_board, board);
      check_value("white_to_move", exp_white_to_move, white_to_move);
      check_value("castle_mask", exp_castle, castle_mask);
      check_value("castle_mask_orig", exp_castle_orig, castle_mask_orig);
      check_value("ep_col", exp_ep_col, ep_col);
      check_value("half_move", exp_half_move, half_move);
      check_value("tt_eval_out", exp_eval[0], tt_eval_out);
      check_value("tt_depth_out", exp_depth[0], tt_depth_out);
      check_value("tt_nodes_out", exp_nodes[0], tt_nodes_out);
      check_value("tt_flag_out", exp_flag[0], tt_flag_out);
      check_value("tt_capture_out", exp_capture[0], tt_capture_out);
      check_value("tt_pulses", exp_pulses[0], {tt_clear, tt_hash_only, tt_store, tt_lookup});
      check_value("qt_eval_out", exp_eval[1], qt_eval_out);
      check_value("qt_depth_out", exp_depth[1], qt_depth_out);
      check_value("qt_nodes_out", exp_nodes[1], qt_nodes_out);
      check_value("qt_flag_out", exp_flag[1], qt_flag_out);
      check_value("qt_capture_out", exp_capture[1], qt_capture_out);
      check_value("qt_pulses", exp_pulses[1], {qt_clear, qt_hash_only, qt_store, qt_lookup});
   endtask

   task automatic randomize_inputs();
      logic [31:0] r;
      bus_data_t w;
      r = $random(seed);
      {gen_idle, moves_ready, move_ready, gen_board_white_to_move, gen_capture,
       gen_white_in_check, gen_black_in_check, gen_fifty_move, gen_insufficient,
       root_mate, root_stalemate, root_fifty_move, root_insufficient, root_check} <= r[13:0];
      {gen_castle, gen_ep_col} <= r[21:14];
      move_count <= r[29:22];
      w = random_word();
      gen_eval <= w[23:0];
      root_eval <= w[47:24];
      {tt_entry_valid, tt_collision, tt_capture_in, tt_idle} <= w[51:48];
      {qt_entry_valid, qt_collision, qt_capture_in, qt_idle} <= w[55:52];
      tt_flag_in <= w[57:56];
      qt_flag_in <= w[59:58];
      tt_depth_in <= w[67:60];
      qt_depth_in <= w[75:68];
      tt_eval_in <= w[99:76];
      qt_eval_in <= w[123:100];
      w = random_word();
      tt_nodes_in <= w[27:0];
      qt_nodes_in <= w[55:28];
      w = random_word();
      tt_hash <= w[79:0];
      w = random_word();
      qt_hash <= w[79:0];
   endtask

   // drives one bus cycle and checks the outputs at the next falling edge
   task automatic bus_cycle(input reg_idx_t i, input logic en, input bus_data_t data,
                            input byte_en_t be);
      logic [31:0] r;
      @(posedge clk);
      update_model();
      r = $random(seed);
      bus_addr <= {i, r[3:0]}; // low nibble is ignored
      bus_en <= en;
      bus_din <= data;
      bus_we <= be;
      randomize_inputs();
      @(negedge clk);
      check_outputs();
   endtask

   function automatic reg_idx_t mapped_read_index(int k);
      reg_idx_t base;
      if (k < 6)
         return reg_idx_t'(k); // ctrl up to castle_orig
      if (k < 11)
         return reg_idx_t'(reg_gen_flags + k - 6);
      base = (k < 16) ? trans_base_main : trans_base_quiet;
      case ((k - 11) % 5)
         0: return base + trans_off_result;
         1: return base + trans_off_status;
         2: return base + trans_off_hash0;
         3: return base + trans_off_hash1;
         default: return base + trans_off_hash2;
      endcase
   endfunction

   initial
   begin
      logic [31:0] r;
      reg_idx_t i;
      reg_idx_t base;
      rst <= 1'b1;
      bus_addr <= '0;
      bus_din <= '0;
      bus_en <= 1'b0;
      bus_we <= '0;
      randomize_inputs();
      reset_model();
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_outputs(); // everything zero out of reset

      repeat (p2_pairs)
      begin
         r = $random(seed);
         i = reg_idx_t'(r[31:16] % 6);
         bus_cycle(i, 1'b1, random_word(), 16'h000f);
         bus_cycle(i, r[0], random_word(), 16'h0000);
      end

      repeat (p3_cycles)
      begin
         r = $random(seed);
         i = r[0] ? reg_board_hi : reg_board_lo;
         bus_cycle(i, r[3:1] != 3'd0, random_word(), r[31:16]);
      end

      repeat (p4_cycles)
      begin
         r = $random(seed);
         base = r[0] ? trans_base_quiet : trans_base_main;
         if (r[2:1] == 2'd3)
            bus_cycle(mapped_read_index(int'(r[31:16]) % 21), r[3], random_word(), 16'h0000);
         else if (r[2:1] == 2'd2)
            bus_cycle(base + trans_off_entry, 1'b1, random_word(), 16'h000f);
         else
            bus_cycle(base + trans_off_cmd, 1'b1, random_word(), 16'h000f);
      end

      repeat (p5_cycles)
      begin
         r = $random(seed);
         if (r[3:0] == 4'd0)
            i = r[31:18]; // any index, mostly unmapped
         else
            i = mapped_read_index(int'(r[31:16]) % 21);
         // writes here land mostly on read only or unmapped indices
         bus_cycle(i, r[4], random_word(), r[5] ? 16'h000f : 16'h0000);
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- files.f
logic/numbat_pkg.sv
logic/move_gen_regs.sv
logic/trans_regs.sv
logic/read_mux.sv
logic/numbat_ctrl.sv
bench/numbat_ctrl_tb.sv

//--- Bender.yml
package:
  name: numbat_ctrl

sources:
  - logic/numbat_pkg.sv
  - logic/move_gen_regs.sv
  - logic/trans_regs.sv
  - logic/read_mux.sv
  - logic/numbat_ctrl.sv
  - target: test
    files:
      - bench/numbat_ctrl_tb.sv
